/* design/adder_tree.sv */
`timescale 1ns/1ps

module adder_tree (
	input  logic              clk,
	input  logic              rstn,
	input  fc_pkg::lane_vec_t terms,
	input  fc_pkg::beat_tag_t tag_in,
	output fc_pkg::data_t     beat_sum,
	output fc_pkg::beat_tag_t tag_out
);

	fc_pkg::data_t     pair0, pair1, pair2;
	fc_pkg::beat_tag_t tag_l1;

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			tag_l1  <= '0;
			tag_out <= '0;
		end
		else
		begin
			tag_l1  <= tag_in;
			tag_out <= tag_l1;
		end
	end

	// level 1 forms three pair sums
	always_ff @(posedge clk)
	begin
		pair0 <= terms.lane0 + terms.lane1;
		pair1 <= terms.lane2 + terms.lane3;
		pair2 <= terms.lane4 + terms.lane5;
	end

	// level 2
	always_ff @(posedge clk)
	begin
		beat_sum <= pair0 + pair1 + pair2; // wraps at 32 bits
	end

endmodule

/* design/beat_sequencer.sv */
`timescale 1ns/1ps

module beat_sequencer (
	input  logic              clk,
	input  logic              rstn,
	input  logic              in_valid,
	input  fc_pkg::lane_vec_t din,
	input  logic              weights_ready,
	input  fc_pkg::sign_vec_t signs,
	output fc_pkg::neuron_t   neuron,
	output fc_pkg::beat_t     beat,
	output fc_pkg::lane_vec_t lanes,
	output fc_pkg::sign_vec_t lane_signs,
	output fc_pkg::beat_tag_t tag
);

	fc_pkg::seq_state_t state, state_nx;
	logic               accept;
	logic               beat_wrap;

	always_comb
	begin
		state_nx = state;
		if (state == fc_pkg::wait_weights && weights_ready)
			state_nx = fc_pkg::run;
	end

	// beats before the weights are in are dropped
	assign accept    = in_valid && (state_nx == fc_pkg::run);
	assign beat_wrap = (beat == fc_pkg::beat_t'(fc_pkg::num_beats - 1));

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
		begin
			state  <= fc_pkg::wait_weights;
			beat   <= '0;
			neuron <= '0;
			tag    <= '0;
		end
		else
		begin
			state <= state_nx;
			tag.valid  <= accept;
			tag.first  <= (beat == '0);
			tag.last   <= beat_wrap;
			tag.neuron <= neuron;
			if (accept)
			begin
				beat <= beat_wrap ? '0 : beat + 1'b1;
				if (beat_wrap)
					neuron <= neuron + 1'b1; // toggles between 0 and 1
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			lanes      <= din;
			lane_signs <= signs;
		end
	end

endmodule

/* design/fc_pkg.sv */
package fc_pkg;

	localparam int num_lanes   = 6;
	localparam int num_beats   = 16;
	localparam int num_neurons = 2;
	localparam int num_weights = num_neurons * num_beats * num_lanes; // 192
	localparam int data_w      = 32;

	// lane values, partial sums and results all wrap mod 2^32
	typedef logic signed [data_w-1:0] data_t;

	typedef logic [$clog2(num_beats)-1:0]     beat_t;
	typedef logic [$clog2(num_neurons)-1:0]   neuron_t;
	typedef logic [$clog2(num_weights+1)-1:0] waddr_t;  // counts 0..192
	typedef logic [num_lanes-1:0]             sign_vec_t; // bit l for lane l

	typedef struct packed {
		data_t lane0;
		data_t lane1;
		data_t lane2;
		data_t lane3;
		data_t lane4;
		data_t lane5;
	} lane_vec_t;

	// travels with each beat down the pipeline
	typedef struct packed {
		logic    valid;
		logic    first;
		logic    last;
		neuron_t neuron;
	} beat_tag_t;

	typedef enum logic {
		wait_weights,
		run
	} seq_state_t;

endpackage

/* design/fc_top.sv */
`timescale 1ns/1ps

module fc_top (
	input  logic              clk,
	input  logic              rstn,
	input  logic              weight,
	input  logic              weight_en,
	input  logic              in_valid,
	input  fc_pkg::lane_vec_t din,
	output logic              weights_ready,
	output logic              out_valid,
	output fc_pkg::data_t     dout,
	output fc_pkg::neuron_t   out_neuron
);

	fc_pkg::sign_vec_t signs;
	fc_pkg::neuron_t   neuron;
	fc_pkg::beat_t     beat;
	fc_pkg::lane_vec_t lanes;
	fc_pkg::sign_vec_t lane_signs;
	fc_pkg::beat_tag_t seq_tag;
	fc_pkg::lane_vec_t terms;
	fc_pkg::beat_tag_t sign_tag;
	fc_pkg::data_t     beat_sum;
	fc_pkg::beat_tag_t sum_tag;

	weight_store u_weight_store (
		.clk           (clk),
		.rstn          (rstn),
		.weight        (weight),
		.weight_en     (weight_en),
		.neuron        (neuron),
		.beat          (beat),
		.signs         (signs),
		.weights_ready (weights_ready)
	);

	beat_sequencer u_beat_sequencer (
		.clk           (clk),
		.rstn          (rstn),
		.in_valid      (in_valid),
		.din           (din),
		.weights_ready (weights_ready),
		.signs         (signs),
		.neuron        (neuron),
		.beat          (beat),
		.lanes         (lanes),
		.lane_signs    (lane_signs),
		.tag           (seq_tag)
	);

	sign_stage u_sign_stage (
		.clk        (clk),
		.rstn       (rstn),
		.lanes      (lanes),
		.lane_signs (lane_signs),
		.tag_in     (seq_tag),
		.terms      (terms),
		.tag_out    (sign_tag)
	);

	adder_tree u_adder_tree (
		.clk      (clk),
		.rstn     (rstn),
		.terms    (terms),
		.tag_in   (sign_tag),
		.beat_sum (beat_sum),
		.tag_out  (sum_tag)
	);

	neuron_accumulator u_neuron_accumulator (
		.clk        (clk),
		.rstn       (rstn),
		.beat_sum   (beat_sum),
		.tag        (sum_tag),
		.out_valid  (out_valid),
		.dout       (dout),
		.out_neuron (out_neuron)
	);

endmodule

/* design/neuron_accumulator.sv */
`timescale 1ns/1ps

module neuron_accumulator (
	input  logic              clk,
	input  logic              rstn,
	input  fc_pkg::data_t     beat_sum,
	input  fc_pkg::beat_tag_t tag,
	output logic              out_valid,
	output fc_pkg::data_t     dout,
	output fc_pkg::neuron_t   out_neuron
);

	fc_pkg::data_t acc;
	fc_pkg::data_t total;

	// first beat restarts the running sum
	always_comb
	begin
		if (tag.first)
			total = beat_sum;
		else
			total = acc + beat_sum;
	end

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
			out_valid <= 1'b0;
		else
			out_valid <= tag.valid && tag.last; // one cycle pulse
	end

	always_ff @(posedge clk)
	begin
		if (tag.valid)
			acc <= total;
	end

	// dout stays put until the next neuron completes
	always_ff @(posedge clk)
	begin
		if (tag.valid && tag.last)
		begin
			dout       <= total;
			out_neuron <= tag.neuron;
		end
	end

endmodule

/* design/sign_stage.sv */
`timescale 1ns/1ps

module sign_stage (
	input  logic              clk,
	input  logic              rstn,
	input  fc_pkg::lane_vec_t lanes,
	input  fc_pkg::sign_vec_t lane_signs,
	input  fc_pkg::beat_tag_t tag_in,
	output fc_pkg::lane_vec_t terms,
	output fc_pkg::beat_tag_t tag_out
);

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
			tag_out <= '0;
		else
			tag_out <= tag_in;
	end

	// weight 1 passes the lane, weight 0 negates it
	always_ff @(posedge clk)
	begin
		terms.lane0 <= lane_signs[0] ? lanes.lane0 : -lanes.lane0;
		terms.lane1 <= lane_signs[1] ? lanes.lane1 : -lanes.lane1;
		terms.lane2 <= lane_signs[2] ? lanes.lane2 : -lanes.lane2;
		terms.lane3 <= lane_signs[3] ? lanes.lane3 : -lanes.lane3;
		terms.lane4 <= lane_signs[4] ? lanes.lane4 : -lanes.lane4;
		terms.lane5 <= lane_signs[5] ? lanes.lane5 : -lanes.lane5;
	end

endmodule

/* design/weight_store.sv */
`timescale 1ns/1ps

module weight_store (
	input  logic              clk,
	input  logic              rstn,
	input  logic              weight,
	input  logic              weight_en,
	input  fc_pkg::neuron_t   neuron,
	input  fc_pkg::beat_t     beat,
	output fc_pkg::sign_vec_t signs,
	output logic              weights_ready
);

	fc_pkg::waddr_t                 load_cnt;
	logic [fc_pkg::num_weights-1:0] w_bits;
	logic                           load;

	assign weights_ready = (load_cnt == fc_pkg::waddr_t'(fc_pkg::num_weights));
	assign load          = weight_en && !weights_ready; // later bits ignored

	always_ff @(posedge clk or negedge rstn)
	begin
		if (!rstn)
			load_cnt <= '0;
		else if (load)
			load_cnt <= load_cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (load)
			w_bits[load_cnt] <= weight;
	end

	// address = neuron*96 + lane*16 + beat
	always_comb
	begin
		for (int l = 0; l < fc_pkg::num_lanes; l++)
		begin
			signs[l] = w_bits[int'(neuron) * fc_pkg::num_beats * fc_pkg::num_lanes
				+ l * fc_pkg::num_beats + int'(beat)];
		end
	end

endmodule

/* list.f */
+incdir+include
design/fc_pkg.sv
design/weight_store.sv
design/beat_sequencer.sv
design/sign_stage.sv
design/adder_tree.sv
design/neuron_accumulator.sv
design/fc_top.sv
testbench/fc_tb.sv

/* include/fc_tb_util.svh */
`ifndef FC_TB_UTIL_SVH
`define FC_TB_UTIL_SVH

// one galois lfsr step whose new bit 0 is the random bit
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic fc_pkg::data_t lane_of(input fc_pkg::lane_vec_t v, input int l);
	case (l)
		0: return v.lane0;
		1: return v.lane1;
		2: return v.lane2;
		3: return v.lane3;
		4: return v.lane4;
		default: return v.lane5;
	endcase
endfunction

// expected result of one neuron over its 16 beats
function automatic fc_pkg::data_t ref_dot(
	input logic [fc_pkg::num_weights-1:0] w,
	input fc_pkg::lane_vec_t              beats [fc_pkg::num_beats],
	input int                             n
);
	fc_pkg::data_t acc;
	fc_pkg::data_t v;
	int            addr;
	acc = '0;
	for (int b = 0; b < fc_pkg::num_beats; b++)
	begin
		for (int l = 0; l < fc_pkg::num_lanes; l++)
		begin
			addr = n * fc_pkg::num_beats * fc_pkg::num_lanes + l * fc_pkg::num_beats + b;
			v    = lane_of(beats[b], l);
			acc  = w[addr] ? acc + v : acc - v;
		end
	end
	return acc;
endfunction

`endif

/* testbench/fc_tb.sv */
`timescale 1ns/1ps

module fc_tb;

	`include "fc_tb_util.svh"

	localparam int seed    = 31;
	localparam int latency = 5;    // edges from driving the last beat to out_valid
	localparam int timeout = 2000;

	logic                           clk, rstn, weight, weight_en, in_valid;
	fc_pkg::lane_vec_t              din;
	logic                           weights_ready, out_valid;
	fc_pkg::data_t                  dout;
	fc_pkg::neuron_t                out_neuron;
	logic [31:0]                    lfsr;
	logic [fc_pkg::num_weights-1:0] wmodel;
	fc_pkg::lane_vec_t              beats [fc_pkg::num_beats];
	fc_pkg::data_t                  exp_val [$];
	int                             exp_neu [$];
	int                             exp_edge [$];
	int                             edge_cnt, next_neuron, value_errors, other_errors;

	fc_top uut (
		.clk           (clk),
		.rstn          (rstn),
		.weight        (weight),
		.weight_en     (weight_en),
		.in_valid      (in_valid),
		.din           (din),
		.weights_ready (weights_ready),
		.out_valid     (out_valid),
		.dout          (dout),
		.out_neuron    (out_neuron)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		edge_cnt <= edge_cnt + 1;

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			r    = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic fc_pkg::lane_vec_t rand_lanes();
		fc_pkg::lane_vec_t v;
		v.lane0 = rand_bits(32);
		v.lane1 = rand_bits(32);
		v.lane2 = rand_bits(32);
		v.lane3 = rand_bits(32);
		v.lane4 = rand_bits(32);
		v.lane5 = rand_bits(32);
		return v;
	endfunction

	task automatic check_value(input string name, input logic signed [31:0] expected,
		input logic signed [31:0] actual);
		if (expected !== actual)
		begin
			value_errors++;
			$display("CHECK FAILED t=%0t %s expected %0d actual %0d",
				$time, name, expected, actual);
		end
	endtask

	// results come out in order so the queue head is the next one
	always @(negedge clk)
	begin
		if (rstn && out_valid)
		begin
			if (exp_val.size() == 0)
			begin
				other_errors++;
				$display("out_valid at %0t with no result expected", $time);
			end
			else
			begin
				check_value("dout", exp_val.pop_front(), dout);
				check_value("out_neuron", exp_neu.pop_front(), out_neuron);
				check_value("out_valid latency", latency, edge_cnt - 1 - exp_edge.pop_front());
			end
		end
	end

	task automatic apply_reset();
		@(posedge clk);
		rstn      <= 1'b0;
		in_valid  <= 1'b0;
		weight_en <= 1'b0;
		repeat (2)
		begin
			@(negedge clk);
			check_value("weights_ready", 0, weights_ready);
			check_value("out_valid", 0, out_valid);
		end
		@(posedge clk);
		rstn <= 1'b1;
		next_neuron = 0;
	endtask

	// extra bits carry the opposite value and must be ignored
	task automatic load_weights(input int extra);
		for (int i = 0; i <= fc_pkg::num_weights + extra; i++)
		begin
			@(posedge clk);
			in_valid  <= 1'b0;
			weight_en <= (i < fc_pkg::num_weights + extra);
			if (i < fc_pkg::num_weights)
			begin
				wmodel[i] = rand_bits(1);
				weight <= wmodel[i];
			end
			else
				weight <= ~wmodel[i % fc_pkg::num_weights];
			@(negedge clk);
			check_value("weights_ready", i >= fc_pkg::num_weights, weights_ready);
		end
	endtask

	task automatic send_beats(input int count, input bit gaps);
		int b;
		b = 0;
		while (b < count)
		begin
			@(posedge clk);
			if (gaps && rand_bits(2) == 3)
				in_valid <= 1'b0; // idle about one cycle in four
			else
			begin
				beats[b] = rand_lanes();
				din      <= beats[b];
				in_valid <= 1'b1;
				if (b == fc_pkg::num_beats - 1)
				begin
					exp_val.push_back(ref_dot(wmodel, beats, next_neuron));
					exp_neu.push_back(next_neuron);
					exp_edge.push_back(edge_cnt);
					next_neuron = 1 - next_neuron;
				end
				b++;
			end
		end
	endtask

	task automatic go_idle();
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic drain_results();
		int n;
		n = 0;
		while (exp_val.size() != 0 && n < timeout)
		begin
			@(posedge clk);
			n++;
		end
		if (exp_val.size() != 0)
		begin
			other_errors++;
			$display("timeout with %0d results still missing", exp_val.size());
		end
	endtask

	initial
	begin
		lfsr         = seed;
		clk          = 1'b0;
		rstn         = 1'b0;
		weight       = 1'b0;
		weight_en    = 1'b0;
		in_valid     = 1'b0;
		din          = '0;
		next_neuron  = 0;
		value_errors = 0;
		other_errors = 0;
		apply_reset();
		repeat (40)
		begin
			@(posedge clk);
			in_valid <= 1'b1; // no weights yet so all are dropped
			din      <= rand_lanes();
		end
		load_weights(24);
		send_beats(fc_pkg::num_beats, 1'b0);
		send_beats(fc_pkg::num_beats, 1'b0);
		repeat (8)
			send_beats(fc_pkg::num_beats, 1'b1);
		go_idle();
		drain_results();
		send_beats(9, 1'b0); // partial neuron, then reset
		apply_reset();
		load_weights(0);
		send_beats(fc_pkg::num_beats, 1'b0);
		send_beats(fc_pkg::num_beats, 1'b1);
		go_idle();
		drain_results();
		repeat (10) @(posedge clk);
		$display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
